/* project.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_ctrl_if.sv
src/dcache_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/dcache_chk.sv
tb/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - src
    files:
      - src/dcache_pkg.sv
      - src/dcache_ctrl_if.sv
      - src/dcache_array.sv
      - src/dcache_ctrl.sv
      - src/dcache_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - tb/dcache_chk.sv
      - tb/dcache_tb.sv

/* tb/dcache_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_defs.svh"

module dcache_tb;

	import dcache_pkg::*;

	// Run limit for the watchdog
	localparam int NUM_TESTS = 5;
	localparam int CYCLES_PER_TEST = 400;
	localparam int CLK_PERIOD = 40;
	// Memory contents before any write
	localparam word_t FILL_KEY = 32'h3c5a_96e1;

	logic CLK;
	logic nRST;
	logic halt;
	logic dmem_ren;
	logic dmem_wen;
	word_t dmem_addr;
	word_t dmem_store;
	logic dhit;
	word_t dmem_load;
	logic flushed;
	logic mem_wait;
	word_t mem_load;
	logic mem_ren;
	logic mem_wen;
	word_t mem_addr;
	word_t mem_store;

	// Sparse memory model by word address
	word_t mem_model [word_t];
	logic req_open;
	int wait_left;

	// Reference model of the CPU view and of the expected backing memory
	word_t ref_data [word_t];
	word_t exp_mem [word_t];
	// Expected tag state per set and way
	tag_t m_tag [`DCACHE_SETS][2];
	logic m_valid [`DCACHE_SETS][2];
	logic m_dirty [`DCACHE_SETS][2];
	logic m_lru [`DCACHE_SETS];

	dcache_top dut (.*);

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t init_word(input word_t a);
		return a ^ FILL_KEY;
	endfunction

	function automatic word_t mem_word(input word_t a);
		return mem_model.exists(a) ? mem_model[a] : init_word(a);
	endfunction

	function automatic word_t ref_word(input word_t a);
		return ref_data.exists(a) ? ref_data[a] : init_word(a);
	endfunction

	function automatic word_t exp_word(input word_t a);
		return exp_mem.exists(a) ? exp_mem[a] : init_word(a);
	endfunction

	// Byte address of one block word
	function automatic word_t mk_addr(input tag_t t, input idx_t i, input logic b);
		return {t, i, b, {`DCACHE_BYTE_OFF_W{1'b0}}};
	endfunction

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			stop_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			stop_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic check_mem(input string name, input word_t a);
		check_word(name, exp_word(a), mem_word(a));
	endtask

	// Both words of an evicted dirty line reach memory
	task automatic model_writeback(input idx_t i, input logic w);
		word_t a;
		for (int b = 0; b < 2; b++) begin
			a = mk_addr(m_tag[i][w], i, b[0]);
			exp_mem[a] = ref_word(a);
		end
	endtask

	// One datapath read or write from request to hit
	task automatic access(input string name, input logic wr, input word_t addr,
		input word_t wdata);
		tag_t t;
		idx_t i;
		logic exp_hit;
		logic way;
		int n;
		t = tag_t'(addr >> (`DCACHE_WORD_W - `DCACHE_TAG_W));
		i = idx_t'(addr >> (`DCACHE_BYTE_OFF_W + 1));
		exp_hit = 1'b0;
		way = m_lru[i];
		for (int k = 0; k < 2; k++) begin
			if (m_valid[i][k] && m_tag[i][k] == t) begin
				exp_hit = 1'b1;
				way = k[0];
			end
		end
		dmem_addr = addr;
		dmem_store = wdata;
		dmem_ren = !wr;
		dmem_wen = wr;
		// Hit answers in the request cycle
		@(negedge CLK);
		check_bit({name, " first cycle dhit"}, exp_hit, dhit);
		if (!exp_hit) begin
			// Victim is the LRU way
			if (m_valid[i][way] && m_dirty[i][way]) begin
				model_writeback(i, way);
			end
			m_tag[i][way] = t;
			m_valid[i][way] = 1'b1;
			m_dirty[i][way] = 1'b0;
			n = 0;
			while (!dhit) begin
				@(negedge CLK);
				n++;
				if (n > 40) begin
					stop_run({name, ": dhit did not rise after the miss"});
				end
			end
		end
		if (wr) begin
			ref_data[addr] = wdata;
			m_dirty[i][way] = 1'b1;
		end else begin
			check_word(name, ref_word(addr), dmem_load);
		end
		m_lru[i] = ~way;
		@(posedge CLK);
		#2;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		@(negedge CLK);
		check_bit("reset dhit", 1'b0, dhit);
		check_bit("reset mem_ren", 1'b0, mem_ren);
		check_bit("reset mem_wen", 1'b0, mem_wen);
		check_bit("reset flushed", 1'b0, flushed);
		@(posedge CLK);
		#2;
		// All lines invalid after reset so this must miss
		access("reset first read", 1'b0, mk_addr(26'h001, 3'd0, 1'b0), '0);
	endtask

	task automatic test_read_miss();
		access("read miss word 0", 1'b0, mk_addr(26'h002, 3'd2, 1'b0), '0);
		access("read fill word 1", 1'b0, mk_addr(26'h002, 3'd2, 1'b1), '0);
		access("read repeat word 0", 1'b0, mk_addr(26'h002, 3'd2, 1'b0), '0);
	endtask

	task automatic test_write_hit();
		word_t a;
		a = mk_addr(26'h003, 3'd4, 1'b1);
		access("write hit fill", 1'b0, a, '0);
		access("write hit store", 1'b1, a, 32'h1234_abcd);
		access("write hit readback", 1'b0, a, '0);
		// Write-back cache leaves memory alone
		check_mem("write hit memory", a);
	endtask

	task automatic test_lru_evict();
		word_t a;
		word_t b;
		word_t c;
		a = mk_addr(26'h010, 3'd6, 1'b0);
		b = mk_addr(26'h011, 3'd6, 1'b1);
		c = mk_addr(26'h012, 3'd6, 1'b0);
		access("lru write a", 1'b1, a, 32'hdead_0a0a);
		access("lru read b", 1'b0, b, '0);
		// Third tag pushes out the dirty line a
		access("lru read c", 1'b0, c, '0);
		check_mem("lru victim memory", a);
		check_word("lru victim data", 32'hdead_0a0a, mem_word(a));
		access("lru b kept", 1'b0, b, '0);
		access("lru a refetch", 1'b0, a, '0);
	endtask

	task automatic test_halt_flush();
		int n;
		access("flush write set 1", 1'b1, mk_addr(26'h020, 3'd1, 1'b0), 32'h0bad_f001);
		access("flush write set 3", 1'b1, mk_addr(26'h021, 3'd3, 1'b1), 32'h0bad_f003);
		access("flush write set 7", 1'b1, mk_addr(26'h022, 3'd7, 1'b0), 32'h0bad_f007);
		access("flush write set 6", 1'b1, mk_addr(26'h011, 3'd6, 1'b1), 32'h0bad_f006);
		halt = 1'b1;
		// Every dirty line is written back
		for (int i = 0; i < `DCACHE_SETS; i++) begin
			for (int w = 0; w < 2; w++) begin
				if (m_valid[i][w] && m_dirty[i][w]) begin
					model_writeback(idx_t'(i), w[0]);
					m_dirty[i][w] = 1'b0;
				end
			end
		end
		n = 0;
		while (!flushed) begin
			@(negedge CLK);
			n++;
			if (n > 300) begin
				stop_run("flushed did not rise after halt");
			end
		end
		check_bit("flush mem_ren", 1'b0, mem_ren);
		check_bit("flush mem_wen", 1'b0, mem_wen);
		foreach (ref_data[k]) begin
			check_word("flush written word", ref_word(k), mem_word(k));
		end
		foreach (exp_mem[k]) begin
			check_mem("flush memory", k);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////////////////////

	// Request waits 0 to 3 cycles and completes on an edge with mem_wait low
	initial begin
		mem_wait = 1'b0;
		mem_load = '0;
		req_open = 1'b0;
		wait_left = 0;
		void'($urandom(32'hc8421d32));
		forever begin
			@(posedge CLK);
			if ((mem_ren || mem_wen) && !mem_wait) begin
				if (mem_wen) begin
					mem_model[mem_addr] = mem_store;
				end
				req_open = 1'b0;
			end
			#2;
			if (mem_ren || mem_wen) begin
				if (!req_open) begin
					req_open = 1'b1;
					wait_left = int'($urandom % 4);
				end else if (wait_left > 0) begin
					wait_left--;
				end
				mem_wait = (wait_left != 0);
				mem_load = mem_word(mem_addr);
			end else begin
				mem_wait = 1'b0;
			end
		end
	end

	// Protocol assertions in the bound checker
	initial begin
		wait (dut.chk.fail_seen);
		stop_run("A memory protocol assertion failed");
	end

	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		stop_run("Watchdog timeout, the tests did not finish in time");
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		nRST = 1'b0;
		halt = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		for (int i = 0; i < `DCACHE_SETS; i++) begin
			m_lru[i] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				m_tag[i][w] = '0;
				m_valid[i][w] = 1'b0;
				m_dirty[i][w] = 1'b0;
			end
		end
		repeat (3) @(posedge CLK);
		#2;
		nRST = 1'b1;
		test_reset();
		test_read_miss();
		test_write_hit();
		test_lru_evict();
		test_halt_flush();
		if (!dut.chk.fail_seen) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/dcache_chk.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_chk (
	input logic              CLK,
	input logic              nRST,
	input logic              mem_ren,
	input logic              mem_wen,
	input logic              mem_wait,
	input dcache_pkg::word_t mem_addr,
	input dcache_pkg::word_t mem_store,
	input logic              flushed
);

	// Set by any failed property, watched by the testbench
	bit fail_seen = 1'b0;

	// One memory command at a time
	one_cmd: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_ren && mem_wen))
	else begin
		fail_seen = 1'b1;
		$error("mem_ren and mem_wen are high together");
	end

	// Stalled request keeps command, address and store data
	held_req: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_ren || mem_wen) && mem_wait |=>
		$stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) &&
		(!mem_wen || $stable(mem_store)))
	else begin
		fail_seen = 1'b1;
		$error("memory request changed while mem_wait was high");
	end

	// Cache is quiet once flushed
	quiet_flushed: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |-> !mem_ren && !mem_wen)
	else begin
		fail_seen = 1'b1;
		$error("memory request while flushed is high");
	end

endmodule

bind dcache_top dcache_chk chk (
	.CLK       (CLK),
	.nRST      (nRST),
	.mem_ren   (mem_ren),
	.mem_wen   (mem_wen),
	.mem_wait  (mem_wait),
	.mem_addr  (mem_addr),
	.mem_store (mem_store),
	.flushed   (flushed)
);

`default_nettype wire

/* src/dcache_top.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_top (
	input  logic                 CLK,
	input  logic                 nRST,
	// Datapath side
	input  logic                 halt,
	input  logic                 dmem_ren,
	input  logic                 dmem_wen,
	input  dcache_pkg::word_t    dmem_addr,
	input  dcache_pkg::word_t    dmem_store,
	output logic                 dhit,
	output dcache_pkg::word_t    dmem_load,
	output logic                 flushed,
	// Memory side, request held until mem_wait falls
	input  logic                 mem_wait,
	input  dcache_pkg::word_t    mem_load,
	output logic                 mem_ren,
	output logic                 mem_wen,
	output dcache_pkg::word_t    mem_addr,
	output dcache_pkg::word_t    mem_store
);

	// Controller to array link
	dcache_ctrl_if ctl_if ();

	// Storage, hit logic and memory muxes
	dcache_array u_array (
		.CLK        (CLK),
		.nRST       (nRST),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_store (dmem_store),
		.dmem_load  (dmem_load),
		.mem_load   (mem_load),
		.mem_wait   (mem_wait),
		.mem_addr   (mem_addr),
		.mem_store  (mem_store),
		.ctl        (ctl_if.array)
	);

	// Miss, write-back and flush FSM
	dcache_ctrl u_ctrl (
		.CLK      (CLK),
		.nRST     (nRST),
		.halt     (halt),
		.dmem_ren (dmem_ren),
		.dmem_wen (dmem_wen),
		.mem_wait (mem_wait),
		.mem_ren  (mem_ren),
		.mem_wen  (mem_wen),
		.flushed  (flushed),
		.ctl      (ctl_if.ctrl)
	);

	// Gated hit goes straight to the datapath
	assign dhit = ctl_if.hit;

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_ctrl (
	input  logic           CLK,
	input  logic           nRST,
	input  logic           halt,
	input  logic           dmem_ren,
	input  logic           dmem_wen,
	input  logic           mem_wait,
	output logic           mem_ren,
	output logic           mem_wen,
	output logic           flushed,
	dcache_ctrl_if.ctrl    ctl
);

	import dcache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	// Datapath asks for a word and the addressed set misses
	logic miss;

	assign miss = (dmem_ren | dmem_wen) && !ctl.hit;

	////////////////////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// Halt takes priority over a pending miss
				if (halt) begin
					next_state = DCHK;
				end else if (miss) begin
					// Modified victim goes back to memory before the fill
					next_state = ctl.victim_dirty ? WB1 : FD1;
				end
			end
			// Miss path, each step waits for its transfer
			WB1: begin
				if (!mem_wait) next_state = WB2;
			end
			WB2: begin
				if (!mem_wait) next_state = FD1;
			end
			FD1: begin
				if (!mem_wait) next_state = FD2;
			end
			FD2: begin
				// Back to IDLE, the request then hits
				if (!mem_wait) next_state = IDLE;
			end
			// Flush loop, one dirty line per pass
			DCHK: begin
				next_state = ctl.any_dirty ? WBD1 : FLUSHED;
			end
			WBD1: begin
				if (!mem_wait) next_state = WBD2;
			end
			WBD2: begin
				if (!mem_wait) next_state = DCHK;
			end
			// Held until reset
			FLUSHED: begin
				next_state = FLUSHED;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		flushed = 1'b0;
		ctl.lookup_en = 1'b0;
		ctl.fill_en = 1'b0;
		ctl.word_sel = 1'b0;
		ctl.wb_src = 1'b0;
		case (state)
			IDLE: begin
				ctl.lookup_en = 1'b1;
			end
			// Victim write-back, word 0 then word 1
			WB1: begin
				mem_wen = 1'b1;
			end
			WB2: begin
				mem_wen = 1'b1;
				ctl.word_sel = 1'b1;
			end
			// Block fill into the LRU way
			FD1: begin
				mem_ren = 1'b1;
				ctl.fill_en = 1'b1;
			end
			FD2: begin
				mem_ren = 1'b1;
				ctl.fill_en = 1'b1;
				ctl.word_sel = 1'b1;
			end
			// Flush write-back from the scanned line
			WBD1: begin
				mem_wen = 1'b1;
				ctl.wb_src = 1'b1;
			end
			WBD2: begin
				mem_wen = 1'b1;
				ctl.wb_src = 1'b1;
				ctl.word_sel = 1'b1;
			end
			FLUSHED: begin
				flushed = 1'b1;
			end
			default: begin
				mem_ren = 1'b0;
			end
		endcase
	end

	// Line clean once its second word has gone out
	assign ctl.clean_en = (state == WBD2) && !mem_wait;

endmodule

`default_nettype wire

/* src/dcache_array.sv */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_defs.svh"

module dcache_array (
	input  logic                 CLK,
	input  logic                 nRST,
	input  logic                 dmem_ren,
	input  logic                 dmem_wen,
	input  dcache_pkg::word_t    dmem_addr,
	input  dcache_pkg::word_t    dmem_store,
	output dcache_pkg::word_t    dmem_load,
	input  dcache_pkg::word_t    mem_load,
	input  logic                 mem_wait,
	output dcache_pkg::word_t    mem_addr,
	output dcache_pkg::word_t    mem_store,
	dcache_ctrl_if.array         ctl
);

	import dcache_pkg::*;

	// Line state, indexed [set][way]
	logic [`DCACHE_SETS-1:0][1:0] valid;
	logic [`DCACHE_SETS-1:0][1:0] dirty;
	// One bit per set, names the way to replace next
	logic [`DCACHE_SETS-1:0] lru;

	// Tags and data, indexed [set][way] and [set][way][word]
	tag_t tags [`DCACHE_SETS][2];
	word_t data [`DCACHE_SETS][2][2];

	// Request address fields
	tag_t req_tag;
	idx_t req_idx;
	logic req_blk;
	logic req;

	// Lookup results
	logic [1:0] way_match;
	logic hit_way;
	logic lru_way;
	logic hit_wr;
	logic fill_wr;

	// Dirty scan result
	line_t scan_line;
	idx_t scan_idx;
	logic scan_way;

	// Line selected for write-back
	idx_t src_idx;
	logic src_way;

	////////////////////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////////////////////

	// Split the byte address, byte offset bits are ignored
	assign req_tag = dmem_addr[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W];
	assign req_idx = dmem_addr[`DCACHE_BYTE_OFF_W+1 +: `DCACHE_IDX_W];
	assign req_blk = dmem_addr[`DCACHE_BYTE_OFF_W];
	assign req = dmem_ren | dmem_wen;

	// Tag compare on both ways of the addressed set
	assign way_match[0] = valid[req_idx][0] && (tags[req_idx][0] == req_tag);
	assign way_match[1] = valid[req_idx][1] && (tags[req_idx][1] == req_tag);

	// Fills only go to the LRU way, so at most one way matches
	assign hit_way = way_match[1];
	assign lru_way = lru[req_idx];

	assign ctl.hit = ctl.lookup_en && req && (|way_match);
	assign ctl.victim_dirty = valid[req_idx][lru_way] && dirty[req_idx][lru_way];

	// Read word by block offset, only meaningful with hit
	assign dmem_load = data[req_idx][hit_way][req_blk];

	// Store on write hit, memory word on each finished fill transfer
	assign hit_wr = ctl.hit && dmem_wen;
	assign fill_wr = ctl.fill_en && !mem_wait;

	////////////////////////////////////////////////////////////////////////////
	// Line state and LRU
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			// Write hit makes the line dirty
			if (hit_wr) begin
				dirty[req_idx][hit_way] <= 1'b1;
			end
			// Any hit points LRU at the other way
			if (ctl.hit) begin
				lru[req_idx] <= ~hit_way;
			end
			// Second fill word completes the line, fresh and clean
			if (fill_wr && ctl.word_sel) begin
				valid[req_idx][lru_way] <= 1'b1;
				dirty[req_idx][lru_way] <= 1'b0;
			end
			// Flush write-back done for the scanned line, either way
			if (ctl.clean_en) begin
				dirty[scan_idx][scan_way] <= 1'b0;
			end
		end
	end

	// Tag and data storage
	always_ff @(posedge CLK) begin
		if (hit_wr) begin
			data[req_idx][hit_way][req_blk] <= dmem_store;
		end
		if (fill_wr) begin
			data[req_idx][lru_way][ctl.word_sel] <= mem_load;
			// New tag lands with the last word
			if (ctl.word_sel) begin
				tags[req_idx][lru_way] <= req_tag;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Dirty scan
	////////////////////////////////////////////////////////////////////////////

	// Last match wins, so the highest numbered dirty line is picked
	always_comb begin
		line_t cand;
		scan_line = '0;
		ctl.any_dirty = 1'b0;
		for (int l = 0; l < 2 * `DCACHE_SETS; l++) begin
			cand = line_t'(l);
			if (dirty[cand[`DCACHE_IDX_W:1]][cand[0]]) begin
				scan_line = cand;
				ctl.any_dirty = 1'b1;
			end
		end
	end

	assign scan_idx = scan_line[`DCACHE_IDX_W:1];
	assign scan_way = scan_line[0];

	////////////////////////////////////////////////////////////////////////////
	// Memory address and store data
	////////////////////////////////////////////////////////////////////////////

	// Victim of the addressed set for a miss, scanned line for the flush
	assign src_idx = ctl.wb_src ? scan_idx : req_idx;
	assign src_way = ctl.wb_src ? scan_way : lru_way;

	// Fills read the requested block, write-backs rebuild the line address
	always_comb begin
		if (ctl.fill_en) begin
			mem_addr = {req_tag, req_idx, ctl.word_sel, {`DCACHE_BYTE_OFF_W{1'b0}}};
		end else begin
			mem_addr = {tags[src_idx][src_way], src_idx, ctl.word_sel,
				{`DCACHE_BYTE_OFF_W{1'b0}}};
		end
	end

	assign mem_store = data[src_idx][src_way][ctl.word_sel];

endmodule

`default_nettype wire

/* src/dcache_ctrl_if.sv */
`default_nettype none
`timescale 1ns/100ps

interface dcache_ctrl_if;

	////////////////////////////////////////////////////////////////////////////
	// Controller to array
	////////////////////////////////////////////////////////////////////////////

	// Tag compare allowed, only in IDLE
	logic lookup_en;
	// Block fill in progress, mem_load goes to the LRU way
	logic fill_en;
	// Block word being moved to or from memory
	logic word_sel;
	// Write-back source, 0 is the victim line, 1 is the scanned dirty line
	logic wb_src;
	// Flush write-back done, clean the scanned line
	logic clean_en;

	////////////////////////////////////////////////////////////////////////////
	// Array to controller
	////////////////////////////////////////////////////////////////////////////

	// Gated hit on the addressed set
	logic hit;
	// LRU way of the addressed set holds modified data
	logic victim_dirty;
	// At least one line anywhere is dirty
	logic any_dirty;

	modport ctrl (
		output lookup_en, fill_en, word_sel, wb_src, clean_en,
		input  hit, victim_dirty, any_dirty
	);

	modport array (
		input  lookup_en, fill_en, word_sel, wb_src, clean_en,
		output hit, victim_dirty, any_dirty
	);

endinterface

`default_nettype wire

/* src/dcache_pkg.sv */
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

	// Data word or byte address
	typedef logic [`DCACHE_WORD_W-1:0] word_t;

	// Upper address bits kept per line
	typedef logic [`DCACHE_TAG_W-1:0] tag_t;

	// Set index
	typedef logic [`DCACHE_IDX_W-1:0] idx_t;

	// Line number for the dirty scan
	// Set index in the upper bits, way in bit 0
	typedef logic [`DCACHE_IDX_W:0] line_t;

	// Controller states
	typedef enum logic [3:0] {
		IDLE    = 4'h1,
		WB1     = 4'h2,
		WB2     = 4'h3,
		FD1     = 4'h4,
		FD2     = 4'h5,
		WBD1    = 4'h6,
		WBD2    = 4'h7,
		DCHK    = 4'h8,
		FLUSHED = 4'hb
	} ctrl_state_t;

endpackage

`default_nettype wire

/* src/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////////////////////

// Datapath word and byte address width
`define DCACHE_WORD_W 32

// Two ways per set, eight sets
`define DCACHE_SETS 8
`define DCACHE_IDX_W 3

// Address split, high to low
// Tag, set index, one block offset bit, byte offset
`define DCACHE_TAG_W 26
`define DCACHE_BYTE_OFF_W 2

`endif
